// File: src/fv_buffer_pkg.sv
`default_nettype none
// shared widths and types for the banked feature-vector buffer
// bank count and region sizes are fixed here

package fv_buffer_pkg;

    // number of banks in the buffer
    localparam int NUM_BANKS = 4;

    // bits in one feature-vector line
    localparam int FV_WIDTH = 64;

    // lines in one iteration region
    localparam int MAX_FV_NUM = 16;

    // iteration regions per sram
    localparam int NUM_ITER = 4;

    // total lines per sram
    localparam int SRAM_DEPTH = NUM_ITER * MAX_FV_NUM;

    // derived field widths
    localparam int LINE_W = $clog2(MAX_FV_NUM);
    localparam int ITER_W = $clog2(NUM_ITER);
    localparam int ADDR_W = $clog2(SRAM_DEPTH);
    // one extra bit so a full region of 16 lines fits
    localparam int FV_NUM_W = $clog2(MAX_FV_NUM + 1);

    // one line of feature data
    typedef logic [FV_WIDTH-1:0] fv_data_t;

    // sram address, region in the upper bits, line in the lower bits
    typedef logic [ADDR_W-1:0] sram_addr_t;

    // line index inside a region
    typedef logic [LINE_W-1:0] line_idx_t;

    // stream length, 0 to MAX_FV_NUM
    typedef logic [FV_NUM_W-1:0] fv_num_t;

    // iteration number selecting a region
    typedef logic [ITER_W-1:0] iter_t;

    // bank controller states
    typedef enum logic [0:0] {
        ST_IDLE,
        ST_STREAM
    } bank_state_e;

endpackage

`default_nettype wire

// File: src/fv_sram.sv
`timescale 1ns/1ps
`default_nettype none
// behavioural single-port sram standing in for a vendor macro
// contents are undefined after power-up and have no reset

module fv_sram (
    // sram clock
    input  wire                         clk,
    // chip enable, active low
    input  wire                         cen,
    // write enable, active low, only valid with cen low
    input  wire                         wen,
    // line address
    input  wire fv_buffer_pkg::sram_addr_t addr,
    // write data
    input  wire fv_buffer_pkg::fv_data_t   d,
    // registered read data
    output fv_buffer_pkg::fv_data_t        q
);

    // storage array
    fv_buffer_pkg::fv_data_t mem [fv_buffer_pkg::SRAM_DEPTH];

    // enabled write
    always_ff @(posedge clk) begin
        if (!cen && !wen) begin
            mem[addr] <= d;
        end
    end

    // enabled read lands on q after the edge
    // q keeps its old value on writes and idle cycles
    always_ff @(posedge clk) begin
        if (!cen && wen) begin
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: src/fv_bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
// per-bank controller, edge requests take the sram ahead of the stream
// iteration inputs and fv_num must stay stable while a stream runs

module fv_bank_ctrl (
    input  wire                            clk,
    input  wire                            arst_n,
    // region used for streams and edge reads
    input  wire fv_buffer_pkg::iter_t      cur_replay_iter,
    // region used for edge writes
    input  wire fv_buffer_pkg::iter_t      cur_update_iter,
    // number of lines per stream
    input  wire fv_buffer_pkg::fv_num_t    fv_num,
    // start pulse, only seen while idle
    input  wire                            stream_begin,
    // edge request strobe
    input  wire                            req_valid,
    // 1 for write, 0 for read
    input  wire                            req_write,
    input  wire fv_buffer_pkg::line_idx_t  req_addr,
    input  wire fv_buffer_pkg::fv_data_t   req_data,
    // sram read data
    input  wire fv_buffer_pkg::fv_data_t   sram_q,
    // sram controls
    output logic                           sram_cen,
    output logic                           sram_wen,
    output fv_buffer_pkg::sram_addr_t      sram_addr,
    output fv_buffer_pkg::fv_data_t        sram_d,
    // stream output towards the small feature buffer
    output logic                           sm_fv_valid,
    output fv_buffer_pkg::fv_data_t        sm_fv_data,
    // edge read response
    output logic                           edge_rd_valid,
    output fv_buffer_pkg::fv_data_t        edge_rd_data,
    // bank idle
    output logic                           available
);

    // fsm state
    fv_buffer_pkg::bank_state_e state_q;
    fv_buffer_pkg::bank_state_e state_d;

    // next stream line to read
    fv_buffer_pkg::line_idx_t line_cnt_q;
    // stream length latched at start
    fv_buffer_pkg::fv_num_t fv_len_q;
    // line count after the current read
    fv_buffer_pkg::fv_num_t line_next;

    // region for the request in this cycle
    fv_buffer_pkg::iter_t req_iter;

    // stream accepted this cycle
    logic start_stream;
    // stream read issued this cycle
    logic stream_rd;
    // final stream read issued this cycle
    logic last_rd;

    // read tags, one cycle behind the sram access
    logic rd_stream_q;
    logic rd_edge_q;

    // stream start
    // zero-length streams are dropped here so the bank stays idle
    assign start_stream = (state_q == fv_buffer_pkg::ST_IDLE)
                        && stream_begin
                        && (fv_num != '0);

    // stream only gets the sram when no request is present
    assign stream_rd = (state_q == fv_buffer_pkg::ST_STREAM) && !req_valid;

    // last line check
    assign line_next = fv_buffer_pkg::fv_num_t'(line_cnt_q) + fv_buffer_pkg::fv_num_t'(1);
    assign last_rd   = stream_rd && (line_next == fv_len_q);

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            fv_buffer_pkg::ST_IDLE: begin
                if (start_stream) begin
                    state_d = fv_buffer_pkg::ST_STREAM;
                end
            end
            fv_buffer_pkg::ST_STREAM: begin
                // leave once the final read is out
                // its data shows up while already idle
                if (last_rd) begin
                    state_d = fv_buffer_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = fv_buffer_pkg::ST_IDLE;
            end
        endcase
    end

    // state, line counter and length
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= fv_buffer_pkg::ST_IDLE;
            line_cnt_q <= '0;
            fv_len_q   <= '0;
        end else begin
            state_q <= state_d;
            if (start_stream) begin
                line_cnt_q <= '0;
                fv_len_q   <= fv_num;
            end else if (stream_rd) begin
                // held while a request steals the sram
                line_cnt_q <= line_cnt_q + 1'b1;
            end
        end
    end

    // writes go to the update region, reads to the replay region
    assign req_iter = req_write ? cur_update_iter : cur_replay_iter;

    // sram arbitration
    always_comb begin
        sram_cen  = 1'b1;
        sram_wen  = 1'b1;
        // default points at the pending stream line
        sram_addr = {cur_replay_iter, line_cnt_q};
        if (req_valid) begin
            sram_cen  = 1'b0;
            sram_wen  = ~req_write;
            sram_addr = {req_iter, req_addr};
        end else if (stream_rd) begin
            sram_cen = 1'b0;
        end
    end

    // only requests write
    assign sram_d = req_data;

    // tag pipeline
    // tells the next cycle who owns sram_q
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_stream_q <= 1'b0;
            rd_edge_q   <= 1'b0;
        end else begin
            rd_stream_q <= stream_rd;
            rd_edge_q   <= req_valid && !req_write;
        end
    end

    // stream output
    assign sm_fv_valid = rd_stream_q;
    assign sm_fv_data  = sram_q;

    // edge response, fixed one-cycle latency
    assign edge_rd_valid = rd_edge_q;
    assign edge_rd_data  = sram_q;

    // idle already covers the cycle handing out the final stream line
    assign available = (state_q == fv_buffer_pkg::ST_IDLE);

endmodule

`default_nettype wire

// File: src/fv_buffer.sv
`timescale 1ns/1ps
`default_nettype none
// top of the banked feature buffer, one controller and one sram per bank
// all banks share the iteration inputs and the stream start

module fv_buffer (
    input  wire                            clk,
    input  wire                            arst_n,
    // region used for streams and edge reads
    input  wire fv_buffer_pkg::iter_t      cur_replay_iter,
    // region used for edge writes
    input  wire fv_buffer_pkg::iter_t      cur_update_iter,
    // lines per stream, same for all banks
    input  wire fv_buffer_pkg::fv_num_t    fv_num,
    // stream start pulse to every bank
    input  wire                            stream_begin,
    // per-bank edge requests
    input  wire [fv_buffer_pkg::NUM_BANKS-1:0]                          req_valid,
    input  wire [fv_buffer_pkg::NUM_BANKS-1:0]                          req_write,
    input  wire fv_buffer_pkg::line_idx_t [fv_buffer_pkg::NUM_BANKS-1:0] req_addr,
    input  wire fv_buffer_pkg::fv_data_t  [fv_buffer_pkg::NUM_BANKS-1:0] req_data,
    // per-bank stream outputs
    output logic [fv_buffer_pkg::NUM_BANKS-1:0]                         sm_fv_valid,
    output fv_buffer_pkg::fv_data_t [fv_buffer_pkg::NUM_BANKS-1:0]      sm_fv_data,
    // per-bank edge read responses
    output logic [fv_buffer_pkg::NUM_BANKS-1:0]                         edge_rd_valid,
    output fv_buffer_pkg::fv_data_t [fv_buffer_pkg::NUM_BANKS-1:0]      edge_rd_data,
    // every bank idle
    output logic                                                        available
);

    // controller to sram
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                          sram_cen;
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                          sram_wen;
    fv_buffer_pkg::sram_addr_t [fv_buffer_pkg::NUM_BANKS-1:0]     sram_addr;
    fv_buffer_pkg::fv_data_t   [fv_buffer_pkg::NUM_BANKS-1:0]     sram_d;

    // sram back to controller
    fv_buffer_pkg::fv_data_t   [fv_buffer_pkg::NUM_BANKS-1:0]     sram_q;

    // per-bank idle flags
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                          available_bank;

    // buffer is free only when no bank is streaming
    assign available = &available_bank;

    // bank controllers
    for (genvar i = 0; i < fv_buffer_pkg::NUM_BANKS; i++) begin : g_bank_ctrl
        fv_bank_ctrl u_bank_ctrl (
            .clk             (clk),
            .arst_n          (arst_n),
            .cur_replay_iter (cur_replay_iter),
            .cur_update_iter (cur_update_iter),
            .fv_num          (fv_num),
            .stream_begin    (stream_begin),
            .req_valid       (req_valid[i]),
            .req_write       (req_write[i]),
            .req_addr        (req_addr[i]),
            .req_data        (req_data[i]),
            .sram_q          (sram_q[i]),
            .sram_cen        (sram_cen[i]),
            .sram_wen        (sram_wen[i]),
            .sram_addr       (sram_addr[i]),
            .sram_d          (sram_d[i]),
            .sm_fv_valid     (sm_fv_valid[i]),
            .sm_fv_data      (sm_fv_data[i]),
            .edge_rd_valid   (edge_rd_valid[i]),
            .edge_rd_data    (edge_rd_data[i]),
            .available       (available_bank[i])
        );
    end

    // one sram per bank
    // regions live side by side in each array
    for (genvar i = 0; i < fv_buffer_pkg::NUM_BANKS; i++) begin : g_sram
        fv_sram u_sram (
            .clk  (clk),
            .cen  (sram_cen[i]),
            .wen  (sram_wen[i]),
            .addr (sram_addr[i]),
            .d    (sram_d[i]),
            .q    (sram_q[i])
        );
    end

endmodule

`default_nettype wire

// File: tests/fv_buffer_properties.sv
`timescale 1ns/1ps
`default_nettype none
// protocol assertions for one bank controller, bound to every instance
// all checks sample on the rising clock edge

module fv_buffer_properties (
    input wire                             clk,
    input wire                             arst_n,
    input wire                             req_valid,
    input wire                             req_write,
    input wire                             sram_cen,
    input wire                             sm_fv_valid,
    input wire                             edge_rd_valid,
    input wire                             available,
    input wire fv_buffer_pkg::bank_state_e state_q
);

    // outputs quiet in the first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !sm_fv_valid && !edge_rd_valid)
        else $error("valid output high in the first cycle after reset");

    // a request always owns the sram
    a_req_enables_sram: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> !sram_cen)
        else $error("request present but sram not enabled");

    // fixed one-cycle read latency, both directions
    a_read_then_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && !req_write) |=> edge_rd_valid)
        else $error("edge read data missing one cycle after a read");

    a_valid_needs_read: assert property (@(posedge clk) disable iff (!arst_n)
        edge_rd_valid |-> $past(req_valid && !req_write))
        else $error("edge read data without a read one cycle earlier");

    // idle bank reports free
    a_idle_available: assert property (@(posedge clk) disable iff (!arst_n)
        (state_q == fv_buffer_pkg::ST_IDLE) |-> available)
        else $error("bank idle but not available");

endmodule

bind fv_bank_ctrl fv_buffer_properties u_properties (
    .clk           (clk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .sram_cen      (sram_cen),
    .sm_fv_valid   (sm_fv_valid),
    .edge_rd_valid (edge_rd_valid),
    .available     (available),
    .state_q       (state_q)
);

`default_nettype wire

// File: tests/fv_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none
// random testbench with a per-bank reference model of the sram regions
// streams and edge reads only touch lines the testbench has written

module fv_buffer_tb;

    logic                                                     clk;
    logic                                                     arst_n;
    fv_buffer_pkg::iter_t                                     cur_replay_iter;
    fv_buffer_pkg::iter_t                                     cur_update_iter;
    fv_buffer_pkg::fv_num_t                                   fv_num;
    logic                                                     stream_begin;
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                      req_valid;
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                      req_write;
    fv_buffer_pkg::line_idx_t [fv_buffer_pkg::NUM_BANKS-1:0]  req_addr;
    fv_buffer_pkg::fv_data_t  [fv_buffer_pkg::NUM_BANKS-1:0]  req_data;
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                      sm_fv_valid;
    fv_buffer_pkg::fv_data_t  [fv_buffer_pkg::NUM_BANKS-1:0]  sm_fv_data;
    logic [fv_buffer_pkg::NUM_BANKS-1:0]                      edge_rd_valid;
    fv_buffer_pkg::fv_data_t  [fv_buffer_pkg::NUM_BANKS-1:0]  edge_rd_data;
    logic                                                     available;

    // model memory, one array per bank
    fv_buffer_pkg::fv_data_t model_mem [fv_buffer_pkg::NUM_BANKS][fv_buffer_pkg::SRAM_DEPTH];
    // expected stream lines, circular per bank, cycle -1 means untimed
    fv_buffer_pkg::fv_data_t sm_exp_data [fv_buffer_pkg::NUM_BANKS][fv_buffer_pkg::SRAM_DEPTH];
    int sm_exp_cyc [fv_buffer_pkg::NUM_BANKS][fv_buffer_pkg::SRAM_DEPTH];
    int sm_wr [fv_buffer_pkg::NUM_BANKS] = '{default: 0};
    int sm_rd [fv_buffer_pkg::NUM_BANKS] = '{default: 0};
    // expected edge reads
    fv_buffer_pkg::fv_data_t edge_exp_data [fv_buffer_pkg::NUM_BANKS][fv_buffer_pkg::SRAM_DEPTH];
    int edge_exp_cyc [fv_buffer_pkg::NUM_BANKS][fv_buffer_pkg::SRAM_DEPTH];
    int edge_wr [fv_buffer_pkg::NUM_BANKS] = '{default: 0};
    int edge_rd [fv_buffer_pkg::NUM_BANKS] = '{default: 0};

    // iteration values as the DUT will see them
    fv_buffer_pkg::iter_t upd_iter;
    fv_buffer_pkg::iter_t rep_iter;

    // counted at falling edges by the monitor
    int    cyc = 0;
    // first cycle in which the latest stream holds available low
    int    busy_from = 0;
    int    seed = 24619;
    int    errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name = "reset";

    fv_buffer u_fv_buffer (
        .clk             (clk),
        .arst_n          (arst_n),
        .cur_replay_iter (cur_replay_iter),
        .cur_update_iter (cur_update_iter),
        .fv_num          (fv_num),
        .stream_begin    (stream_begin),
        .req_valid       (req_valid),
        .req_write       (req_write),
        .req_addr        (req_addr),
        .req_data        (req_data),
        .sm_fv_valid     (sm_fv_valid),
        .sm_fv_data      (sm_fv_data),
        .edge_rd_valid   (edge_rd_valid),
        .edge_rd_data    (edge_rd_data),
        .available       (available)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            errors = errors + 1;
            $display("ERROR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("%s: %s", test_name, what);
    endtask

    function automatic fv_buffer_pkg::fv_data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic bit queues_empty();
        bit empty;
        empty = 1'b1;
        for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
            empty &= (sm_wr[b] == sm_rd[b]) && (edge_wr[b] == edge_rd[b]);
        end
        return empty;
    endfunction

    // new cycle, strobes drop unless driven again
    task automatic next_cycle();
        @(posedge clk);
        req_valid    <= '0;
        req_write    <= '0;
        stream_begin <= 1'b0;
    endtask

    task automatic set_iters(input fv_buffer_pkg::iter_t upd, input fv_buffer_pkg::iter_t rep);
        next_cycle();
        cur_update_iter <= upd;
        cur_replay_iter <= rep;
        upd_iter = upd;
        rep_iter = rep;
    endtask

    // edge request in the current cycle, model updated at once
    task automatic send_req(input int b, input logic wr, input fv_buffer_pkg::line_idx_t a,
                            input fv_buffer_pkg::fv_data_t d);
        int idx;
        req_valid[b] <= 1'b1;
        req_write[b] <= wr;
        req_addr[b]  <= a;
        req_data[b]  <= d;
        if (wr) begin
            model_mem[b][{upd_iter, a}] = d;
        end else begin
            idx = edge_wr[b] % fv_buffer_pkg::SRAM_DEPTH;
            edge_exp_data[b][idx] = model_mem[b][{rep_iter, a}];
            // sampled at the next edge, data one edge later
            edge_exp_cyc[b][idx] = cyc + 2;
            edge_wr[b] = edge_wr[b] + 1;
        end
    endtask

    task automatic begin_stream(input int n, input bit timed);
        int idx;
        next_cycle();
        fv_num       <= fv_buffer_pkg::fv_num_t'(n);
        stream_begin <= 1'b1;
        for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
            for (int k = 0; k < n; k++) begin
                idx = sm_wr[b] % fv_buffer_pkg::SRAM_DEPTH;
                sm_exp_data[b][idx] = model_mem[b][{rep_iter, fv_buffer_pkg::line_idx_t'(k)}];
                // line k lands k+2 cycles after the sampling cycle
                sm_exp_cyc[b][idx] = timed ? cyc + 3 + k : -1;
                sm_wr[b] = sm_wr[b] + 1;
            end
        end
        if (n != 0) begin
            busy_from = cyc + 2;
        end
    endtask

    // writes every line of one region in all banks
    task automatic fill_region(input fv_buffer_pkg::iter_t r);
        set_iters(r, r);
        for (int k = 0; k < fv_buffer_pkg::MAX_FV_NUM; k++) begin
            next_cycle();
            for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                send_req(b, 1'b1, fv_buffer_pkg::line_idx_t'(k), rand_data());
            end
        end
    endtask

    task automatic wait_idle();
        int i;
        i = 0;
        while (!queues_empty() && i < 200) begin
            next_cycle();
            i = i + 1;
        end
        if (!queues_empty()) begin
            report_failure("timed out waiting for stream lines and edge read data");
        end
        i = 0;
        // available is read between edges
        do begin
            @(negedge clk);
            i = i + 1;
        end while (!available && i < 200);
        if (!available) begin
            report_failure("timed out waiting for available to return high");
        end
    endtask

    task automatic finish_test(input int err_start);
        if (errors == err_start) begin
            tests_passed = tests_passed + 1;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d errors", test_name, errors - err_start);
        end
    endtask

    // response monitor, everything sampled at the falling edge
    always @(negedge clk) begin
        logic exp_avail;
        int   idx;
        cyc = cyc + 1;
        if (arst_n) begin
            exp_avail = 1'b1;
            for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                // bank busy from the stream start until its last line shows
                if (cyc >= busy_from && sm_wr[b] != sm_rd[b]
                    && !(sm_wr[b] - sm_rd[b] == 1 && sm_fv_valid[b])) begin
                    exp_avail = 1'b0;
                end
                if (sm_fv_valid[b]) begin
                    if (sm_wr[b] == sm_rd[b]) begin
                        report_failure($sformatf("unexpected stream line on bank %0d", b));
                    end else begin
                        idx = sm_rd[b] % fv_buffer_pkg::SRAM_DEPTH;
                        check($sformatf("stream data bank %0d", b), sm_exp_data[b][idx],
                              sm_fv_data[b]);
                        if (sm_exp_cyc[b][idx] >= 0) begin
                            check($sformatf("stream cycle bank %0d", b), sm_exp_cyc[b][idx], cyc);
                        end
                        sm_rd[b] = sm_rd[b] + 1;
                    end
                end
                if (edge_rd_valid[b]) begin
                    if (edge_wr[b] == edge_rd[b]) begin
                        report_failure($sformatf("edge read data without a request on bank %0d", b));
                    end else begin
                        idx = edge_rd[b] % fv_buffer_pkg::SRAM_DEPTH;
                        check($sformatf("edge data bank %0d", b), edge_exp_data[b][idx],
                              edge_rd_data[b]);
                        check($sformatf("edge cycle bank %0d", b), edge_exp_cyc[b][idx], cyc);
                        edge_rd[b] = edge_rd[b] + 1;
                    end
                end
            end
            check("available", exp_avail, available);
        end
    end

    task automatic write_read_back();
        int err_start;
        fv_buffer_pkg::iter_t r;
        fv_buffer_pkg::line_idx_t addr_log [fv_buffer_pkg::NUM_BANKS][8];
        test_name = "write_read";
        err_start = errors;
        for (int t = 0; t < 2; t++) begin
            r = fv_buffer_pkg::iter_t'(rand_below(fv_buffer_pkg::NUM_ITER));
            set_iters(r, r);
            for (int n = 0; n < 8; n++) begin
                next_cycle();
                for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                    addr_log[b][n] = fv_buffer_pkg::line_idx_t'(rand_below(16));
                    send_req(b, 1'b1, addr_log[b][n], rand_data());
                end
            end
            // read back, the first one right behind the last write
            for (int n = 7; n >= 0; n--) begin
                next_cycle();
                for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                    send_req(b, 1'b0, addr_log[b][n], '0);
                end
            end
        end
        wait_idle();
        finish_test(err_start);
    endtask

    task automatic region_separation();
        int err_start;
        fv_buffer_pkg::line_idx_t a;
        fv_buffer_pkg::fv_data_t  d;
        test_name = "region_separation";
        err_start = errors;
        a = fv_buffer_pkg::line_idx_t'(rand_below(16));
        for (int r = 0; r < fv_buffer_pkg::NUM_ITER; r++) begin
            set_iters(fv_buffer_pkg::iter_t'(r), rep_iter);
            for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                d = rand_data();
                // region number in the top bits keeps the data distinct
                d[63:62] = r[1:0];
                send_req(b, 1'b1, a, d);
            end
        end
        for (int r = 0; r < fv_buffer_pkg::NUM_ITER; r++) begin
            set_iters(upd_iter, fv_buffer_pkg::iter_t'(r));
            for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                send_req(b, 1'b0, a, '0);
            end
        end
        wait_idle();
        finish_test(err_start);
    endtask

    task automatic stream_plain();
        int err_start;
        test_name = "stream_plain";
        err_start = errors;
        fill_region(fv_buffer_pkg::iter_t'(rand_below(fv_buffer_pkg::NUM_ITER)));
        for (int t = 0; t < 3; t++) begin
            begin_stream(1 + rand_below(16), 1'b1);
            wait_idle();
        end
        finish_test(err_start);
    endtask

    task automatic stream_with_requests();
        int err_start;
        fv_buffer_pkg::iter_t r;
        fv_buffer_pkg::line_idx_t a;
        test_name = "stream_with_requests";
        err_start = errors;
        for (int t = 0; t < 2; t++) begin
            r = fv_buffer_pkg::iter_t'(rand_below(fv_buffer_pkg::NUM_ITER));
            fill_region(r);
            // writes go elsewhere so the streamed region stays fixed
            set_iters(fv_buffer_pkg::iter_t'(r + 1), r);
            begin_stream(8 + rand_below(9), 1'b0);
            for (int c = 0; c < 24; c++) begin
                next_cycle();
                for (int b = 0; b < fv_buffer_pkg::NUM_BANKS; b++) begin
                    if (rand_below(3) == 0) begin
                        a = fv_buffer_pkg::line_idx_t'(rand_below(16));
                        send_req(b, rand_below(2) == 1, a, rand_data());
                    end
                end
            end
            wait_idle();
        end
        finish_test(err_start);
    endtask

    task automatic ignored_and_empty_streams();
        int err_start;
        test_name = "ignored_and_empty_stream";
        err_start = errors;
        begin_stream(10, 1'b1);
        repeat (3) next_cycle();
        // bank is mid-stream, this start must be dropped
        stream_begin <= 1'b1;
        wait_idle();
        begin_stream(0, 1'b1);
        repeat (10) next_cycle();
        wait_idle();
        finish_test(err_start);
    endtask

    initial begin
        arst_n          = 1'b0;
        cur_replay_iter = '0;
        cur_update_iter = '0;
        fv_num          = '0;
        stream_begin    = 1'b0;
        req_valid       = '0;
        req_write       = '0;
        req_addr        = '0;
        req_data        = '0;
        upd_iter        = '0;
        rep_iter        = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        write_read_back();
        region_separation();
        stream_plain();
        stream_with_requests();
        ignored_and_empty_streams();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/fv_buffer_pkg.sv
src/fv_sram.sv
src/fv_bank_ctrl.sv
src/fv_buffer.sv
tests/fv_buffer_properties.sv
tests/fv_buffer_tb.sv

// File: Bender.yml
package:
  name: fv_buffer

dependencies: {}

sources:
  # design, package first
  - src/fv_buffer_pkg.sv
  - src/fv_sram.sv
  - src/fv_bank_ctrl.sv
  - src/fv_buffer.sv

  # testbench and bound assertions
  - target: test
    files:
      - tests/fv_buffer_properties.sv
      - tests/fv_buffer_tb.sv
